// File: bench/tb_pipe_model.svh
/*
 * Stimulus table and architectural model, included inside tb_pipe.
 * Every register r1 to r15 is seeded by ADDI before any row reads it.
 */
`ifndef TB_PIPE_MODEL_SVH
`define TB_PIPE_MODEL_SVH

// Instruction fields of one row with the hold cycles in front of it and its expected data
typedef struct packed {
	pipe_pkg::opcode_t   op;
	pipe_pkg::reg_addr_t rd;
	pipe_pkg::reg_addr_t ra;
	pipe_pkg::reg_addr_t rb;
	pipe_pkg::imm_t      imm;
	int                  hold_len;
	pipe_pkg::instr_t    word;
	pipe_pkg::word_t     exp_data;
} row_t;

row_t            table_rows [$];
// Rows that retire a result in issue order
int              expected_q [$];
pipe_pkg::word_t arch_regs [pipe_pkg::NUM_REGS];
int              mul_rows;

// Field layout is opcode, rd, ra, rb and imm from the top bit down
function automatic pipe_pkg::instr_t encode_instr(input pipe_pkg::opcode_t op,
	input pipe_pkg::reg_addr_t rd, input pipe_pkg::reg_addr_t ra,
	input pipe_pkg::reg_addr_t rb, input pipe_pkg::imm_t imm);
	pipe_pkg::instr_t w;
	w = '0;
	w[pipe_pkg::OPC_MSB -: pipe_pkg::OPC_W] = op;
	w[pipe_pkg::RD_MSB -: pipe_pkg::REG_ADDR_W] = rd;
	w[pipe_pkg::RA_MSB -: pipe_pkg::REG_ADDR_W] = ra;
	w[pipe_pkg::RB_MSB -: pipe_pkg::REG_ADDR_W] = rb;
	w[pipe_pkg::IMM_MSB -: pipe_pkg::IMM_W] = imm;
	return w;
endfunction

task automatic add_row(input pipe_pkg::opcode_t op, input int rd, input int ra, input int rb,
	input int imm, input int hold_len);
	row_t row;
	row.op       = op;
	row.rd       = pipe_pkg::reg_addr_t'(rd);
	row.ra       = pipe_pkg::reg_addr_t'(ra);
	row.rb       = pipe_pkg::reg_addr_t'(rb);
	row.imm      = pipe_pkg::imm_t'(imm);
	row.hold_len = hold_len;
	row.word     = encode_instr(row.op, row.rd, row.ra, row.rb, row.imm);
	row.exp_data = '0;
	table_rows.push_back(row);
endtask

////////////////////////////////////////////////////////////////////////////
// Architectural result of one operation
function automatic pipe_pkg::word_t expected_result(input pipe_pkg::opcode_t op,
	input pipe_pkg::word_t a, input pipe_pkg::word_t b, input pipe_pkg::imm_t imm);
	pipe_pkg::word_t ext_imm;
	pipe_pkg::word_t res;
	ext_imm = pipe_pkg::word_t'($signed(imm));
	case (op)
		pipe_pkg::OP_ADD:  res = a + b;
		pipe_pkg::OP_SUB:  res = a - b;
		pipe_pkg::OP_AND:  res = a & b;
		pipe_pkg::OP_OR:   res = a | b;
		pipe_pkg::OP_XOR:  res = a ^ b;
		pipe_pkg::OP_SLL:  res = a << (b % 32);
		pipe_pkg::OP_ADDI: res = a + ext_imm;
		// Low half of the full product
		pipe_pkg::OP_MUL:  res = a * b;
		default:           res = '0;
	endcase
	return res;
endfunction

// Walk the table in issue order and fill in the expected data
task automatic run_model();
	pipe_pkg::word_t res;
	foreach (arch_regs[r]) begin
		arch_regs[r] = '0;
	end
	mul_rows = 0;
	foreach (table_rows[i]) begin
		if (table_rows[i].op == pipe_pkg::OP_MUL) begin
			mul_rows++;
		end
		if (table_rows[i].op != pipe_pkg::OP_NOP) begin
			res = expected_result(table_rows[i].op, arch_regs[table_rows[i].ra],
				arch_regs[table_rows[i].rb], table_rows[i].imm);
			table_rows[i].exp_data = res;
			expected_q.push_back(i);
			// r0 still shows its result on the port but keeps reading zero
			if (table_rows[i].rd != '0) begin
				arch_regs[table_rows[i].rd] = res;
			end
		end
	end
endtask

`endif

// File: bench/tb_pipe.sv
/*
 * Table-driven testbench for pipe_top, checked against an architectural model.
 * Results are compared in issue order, a missing result ends in a timeout.
 */
`default_nettype none

module tb_pipe;

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int READY_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 200;
	localparam int SEED          = 79473;

	logic                clk;
	logic                reset;
	logic                instr_valid;
	pipe_pkg::instr_t    instr;
	logic                hold;
	logic                instr_ready;
	logic                wb_valid;
	pipe_pkg::reg_addr_t wb_addr;
	pipe_pkg::word_t     wb_data;

	// Monitor side counters
	int value_errors     = 0;
	int protocol_errors  = 0;
	int ready_low_cycles = 0;
	int check_idx        = 0;
	// Drive side counters
	int timeout_errors   = 0;
	int state_errors     = 0;
	bit timed_out        = 1'b0;

	`include "tb_pipe_model.svh"

	pipe_top UUT (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.hold        (hold),
		.instr_ready (instr_ready),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	task automatic build_table();
		// Seed r1 to r15 from r0 with random immediates
		for (int r = 1; r < pipe_pkg::NUM_REGS; r++) begin
			add_row(pipe_pkg::OP_ADDI, r, 0, 0, int'($urandom & 32'hFF), 0);
		end
		// Forwarding at distance one and two
		add_row(pipe_pkg::OP_ADD, 1, 2, 3, 0, 0);
		add_row(pipe_pkg::OP_SUB, 4, 1, 5, 0, 0);
		add_row(pipe_pkg::OP_AND, 6, 7, 1, 0, 0);
		add_row(pipe_pkg::OP_OR, 8, 4, 6, 0, 0);
		add_row(pipe_pkg::OP_XOR, 9, 8, 2, 0, 0);
		add_row(pipe_pkg::OP_SLL, 10, 9, 11, 0, 0);
		// Negative immediates with the first row behind a hold while results are in flight
		add_row(pipe_pkg::OP_ADDI, 11, 10, 0, -5, 4);
		add_row(pipe_pkg::OP_ADDI, 12, 11, 0, -128, 0);
		add_row(pipe_pkg::OP_ADDI, 13, 12, 0, 127, 0);
		// Write to r0 then read it back at distance one and two
		add_row(pipe_pkg::OP_ADD, 0, 1, 2, 0, 0);
		add_row(pipe_pkg::OP_ADD, 14, 0, 3, 0, 0);
		add_row(pipe_pkg::OP_OR, 15, 0, 13, 0, 0);
		// MUL with dependents right behind it
		add_row(pipe_pkg::OP_MUL, 5, 1, 2, 0, 0);
		add_row(pipe_pkg::OP_ADD, 6, 5, 5, 0, 0);
		add_row(pipe_pkg::OP_MUL, 7, 6, 13, 0, 0);
		add_row(pipe_pkg::OP_SUB, 8, 4, 7, 0, 0);
		// Hold lands while the MUL is busy
		add_row(pipe_pkg::OP_NOP, 0, 0, 0, 0, 3);
		add_row(pipe_pkg::OP_MUL, 9, 5, 7, 0, 3);
		add_row(pipe_pkg::OP_MUL, 10, 9, 9, 0, 0);
		add_row(pipe_pkg::OP_XOR, 11, 10, 9, 0, 0);
		add_row(pipe_pkg::OP_ADD, 12, 11, 10, 0, 6);
		add_row(pipe_pkg::OP_SLL, 13, 12, 3, 0, 0);
		add_row(pipe_pkg::OP_NOP, 0, 0, 0, 0, 0);
		add_row(pipe_pkg::OP_ADDI, 1, 13, 0, 1, 0);
		add_row(pipe_pkg::OP_AND, 2, 1, 12, 0, 0);
		add_row(pipe_pkg::OP_ADD, 3, 2, 1, 0, 0);
		add_row(pipe_pkg::OP_SUB, 4, 3, 0, 0, 2);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive side is entered right after a rising edge
	task automatic issue_row(input int i);
		int waited;
		instr       <= table_rows[i].word;
		instr_valid <= 1'b1;
		if (table_rows[i].hold_len > 0) begin
			hold <= 1'b1;
			repeat (table_rows[i].hold_len) @(posedge clk);
			hold <= 1'b0;
		end
		// Ready at the falling edge is what the next rising edge sees
		waited = 0;
		@(negedge clk);
		while (!instr_ready && waited < READY_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (!instr_ready) begin
			timed_out = 1'b1;
			timeout_errors++;
			$display("Timeout at %0t: instr_ready stayed low for table row %0d",
				$time, i);
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (check_idx < expected_q.size() && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (check_idx < expected_q.size()) begin
			timed_out = 1'b1;
			timeout_errors++;
			$display("Timeout at %0t: %0d results never arrived", $time,
				expected_q.size() - check_idx);
		end
	endtask

	task automatic finish_run();
		$display("Errors: value %0d, protocol %0d, state %0d, timeout %0d",
			value_errors, protocol_errors, state_errors, timeout_errors);
		if (value_errors + protocol_errors + state_errors + timeout_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		hold        = 1'b0;
		void'($urandom(SEED));
		build_table();
		run_model();

		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (instr_ready == 1'b1) else begin
			state_errors++;
			$display("FAIL time=%0t signal=instr_ready expected=1 actual=%0b",
				$time, instr_ready);
		end
		assert (wb_valid == 1'b0) else begin
			state_errors++;
			$display("FAIL time=%0t signal=wb_valid expected=0 actual=%0b",
				$time, wb_valid);
		end
		@(posedge clk);

		foreach (table_rows[i]) begin
			if (!timed_out) begin
				issue_row(i);
			end
		end
		instr_valid <= 1'b0;

		if (!timed_out) begin
			wait_drain();
		end
		if (!timed_out) begin
			// Quiet window to catch a duplicated result
			repeat (2 * pipe_pkg::MUL_STEPS) @(posedge clk);
			// Each MUL keeps decode frozen for all of its steps
			assert (ready_low_cycles == pipe_pkg::MUL_STEPS * mul_rows) else begin
				state_errors++;
				$display("instr_ready low for %0d cycles outside hold, %0d MULs need %0d",
					ready_low_cycles, mul_rows, pipe_pkg::MUL_STEPS * mul_rows);
			end
		end
		finish_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor sampling at the falling edge
	task automatic check_result();
		int row;
		assert (check_idx < expected_q.size()) else begin
			protocol_errors++;
			$display("Extra result at %0t: wb_addr=%0d wb_data=%h with nothing left",
				$time, wb_addr, wb_data);
		end
		if (check_idx < expected_q.size()) begin
			row = expected_q[check_idx];
			check_idx++;
			assert (wb_addr == table_rows[row].rd) else begin
				value_errors++;
				$display("FAIL time=%0t signal=wb_addr expected=%0d actual=%0d",
					$time, table_rows[row].rd, wb_addr);
			end
			assert (wb_data == table_rows[row].exp_data) else begin
				value_errors++;
				$display("FAIL time=%0t signal=wb_data expected=%h actual=%h",
					$time, table_rows[row].exp_data, wb_data);
			end
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			// Only a busy MUL may drop ready outside hold
			if (!hold && !instr_ready) begin
				ready_low_cycles++;
			end
			// No result may leave while hold is high
			assert (!(hold && wb_valid)) else begin
				protocol_errors++;
				$display("FAIL time=%0t signal=wb_valid expected=0 actual=%0b",
					$time, wb_valid);
			end
			if (wb_valid) begin
				check_result();
			end
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+bench
verilog/pipe_pkg.sv
verilog/pipe_if.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/operand_mux.sv
verilog/alu_execute.sv
verilog/result_stage.sv
verilog/pipe_top.sv
bench/tb_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator, all output lands in sim.log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module tb_pipe -Mdir obj_dir -o tb_pipe \
	-f compile.f > "$LOG" 2>&1 &&
	./obj_dir/tb_pipe >> "$LOG" 2>&1 ||
	echo "Build or simulation exited with an error" >> "$LOG"

cat "$LOG"

# Verdict comes from the log, a run without a verdict counts as failed
grep -q "TB FAILED" "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q "TB PASSED" "$LOG" || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

// File: verilog/alu_execute.sv
/*
 * Execute stage, single-cycle ALU plus a four-step shift-add multiplier.
 * MUL keeps the low 32 bits only, and hold freezes every stage.
 */
`default_nettype none

module alu_execute (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  hold,
	output logic                 id_freeze,
	output logic                 ex_freeze,
	id_ex_if.execute_mp          id_ex,
	fwd_if.ex_mp                 fwd,
	output logic                 ex_valid,
	output pipe_pkg::reg_addr_t  ex_rd,
	output pipe_pkg::word_t      ex_result
);

	pipe_pkg::mul_state_e mul_state;
	pipe_pkg::mul_cnt_t   mul_cnt;
	logic                 is_mul;
	logic                 mul_last;

	// Multiplier data path, registered and current step views
	pipe_pkg::word_t acc_q;
	pipe_pkg::word_t mcand_q;
	pipe_pkg::word_t mplier_q;
	pipe_pkg::word_t acc_cur;
	pipe_pkg::word_t mcand_cur;
	pipe_pkg::word_t mplier_cur;
	pipe_pkg::word_t partial;
	pipe_pkg::word_t mul_sum;
	pipe_pkg::word_t alu_out;

	assign is_mul   = id_ex.valid && (id_ex.op == pipe_pkg::OP_MUL);
	assign mul_last = (mul_state == pipe_pkg::MUL_BUSY) && (mul_cnt == pipe_pkg::MUL_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Freeze generation
	// Execute moves on the last MUL step, decode waits one more cycle
	assign ex_freeze = hold || (is_mul && !mul_last);
	assign id_freeze = hold || is_mul;

	////////////////////////////////////////////////////////////////////////////
	// Multiplier
	// First step works straight off the operand registers
	always_comb begin
		if (mul_state == pipe_pkg::MUL_IDLE) begin
			acc_cur    = '0;
			mcand_cur  = id_ex.operand_a;
			mplier_cur = id_ex.operand_b;
		end else begin
			acc_cur    = acc_q;
			mcand_cur  = mcand_q;
			mplier_cur = mplier_q;
		end
	end

	// One 8-bit slice of B per step
	assign partial = mcand_cur * pipe_pkg::word_t'(mplier_cur[pipe_pkg::MUL_STEP_W-1:0]);
	assign mul_sum = acc_cur + partial;

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_state <= pipe_pkg::MUL_IDLE;
			mul_cnt   <= '0;
		end else if (!hold) begin
			case (mul_state)
				pipe_pkg::MUL_IDLE: begin
					if (is_mul) begin
						mul_state <= pipe_pkg::MUL_BUSY;
						mul_cnt   <= pipe_pkg::mul_cnt_t'(1);
					end
				end
				pipe_pkg::MUL_BUSY: begin
					if (mul_last) begin
						mul_state <= pipe_pkg::MUL_IDLE;
						mul_cnt   <= '0;
					end else begin
						mul_cnt <= mul_cnt + pipe_pkg::mul_cnt_t'(1);
					end
				end
				default: mul_state <= pipe_pkg::MUL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && is_mul) begin
			acc_q    <= mul_sum;
			mcand_q  <= mcand_cur << pipe_pkg::MUL_STEP_W;
			mplier_q <= mplier_cur >> pipe_pkg::MUL_STEP_W;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	always_comb begin
		case (id_ex.op)
			pipe_pkg::OP_ADD,
			pipe_pkg::OP_ADDI: alu_out = id_ex.operand_a + id_ex.operand_b;
			pipe_pkg::OP_SUB:  alu_out = id_ex.operand_a - id_ex.operand_b;
			pipe_pkg::OP_AND:  alu_out = id_ex.operand_a & id_ex.operand_b;
			pipe_pkg::OP_OR:   alu_out = id_ex.operand_a | id_ex.operand_b;
			pipe_pkg::OP_XOR:  alu_out = id_ex.operand_a ^ id_ex.operand_b;
			pipe_pkg::OP_SLL:
				alu_out = id_ex.operand_a << id_ex.operand_b[pipe_pkg::SHAMT_W-1:0];
			// Product is only meaningful on the last step
			pipe_pkg::OP_MUL:  alu_out = mul_sum;
			default:           alu_out = '0;
		endcase
	end

	// Result counts as final for single-cycle ops or the last MUL step
	assign ex_valid  = id_ex.valid && (!is_mul || mul_last);
	assign ex_rd     = id_ex.rd;
	assign ex_result = alu_out;

	assign fwd.ex_valid = ex_valid;
	assign fwd.ex_rd    = ex_rd;
	assign fwd.ex_forw  = ex_result;

	// Decode issues a bubble after a MUL, so no back-to-back start
	assert property (@(posedge clk) disable iff (reset)
		(mul_last && !hold) |=> (mul_state == pipe_pkg::MUL_IDLE) && !id_ex.valid);

endmodule

`default_nettype wire

// File: verilog/instr_decode.sv
/*
 * Decode stage with valid/ready issue port and forward select generation.
 * Source must hold instr stable while instr_valid is high and ready is low.
 */
`default_nettype none

module instr_decode (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      instr_valid,
	input  wire pipe_pkg::instr_t    instr,
	output logic                     instr_ready,
	input  wire                      id_freeze,
	input  wire                      ex_freeze,
	output pipe_pkg::reg_addr_t      ra_addr,
	output pipe_pkg::reg_addr_t      rb_addr,
	output pipe_pkg::word_t          simm,
	output pipe_pkg::opsel_t         sel_a,
	output pipe_pkg::opsel_t         sel_b,
	id_ex_if.decode_mp               id_ex,
	fwd_if.decode_mp                 fwd
);

	logic                dec_valid;
	pipe_pkg::instr_t    dec_instr;
	pipe_pkg::opcode_t   dec_op;
	pipe_pkg::reg_addr_t dec_rd;
	pipe_pkg::imm_t      dec_imm;
	logic                take;
	logic                a_ex_hit;
	logic                a_wb_hit;
	logic                b_ex_hit;
	logic                b_wb_hit;

	// Accept only while decode is free to move
	assign instr_ready = !id_freeze;
	assign take        = instr_valid && instr_ready;

	////////////////////////////////////////////////////////////////////////////
	// Decode register
	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (!id_freeze) begin
			// No new word means a bubble
			dec_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			dec_instr <= instr;
		end
	end

	// Field split
	assign dec_op  = dec_instr[pipe_pkg::OPC_MSB -: pipe_pkg::OPC_W];
	assign dec_rd  = dec_instr[pipe_pkg::RD_MSB -: pipe_pkg::REG_ADDR_W];
	assign ra_addr = dec_instr[pipe_pkg::RA_MSB -: pipe_pkg::REG_ADDR_W];
	assign rb_addr = dec_instr[pipe_pkg::RB_MSB -: pipe_pkg::REG_ADDR_W];
	assign dec_imm = dec_instr[pipe_pkg::IMM_MSB -: pipe_pkg::IMM_W];

	// Sign-extended immediate for ADDI
	assign simm = {{(pipe_pkg::WORD_W - pipe_pkg::IMM_W){dec_imm[pipe_pkg::IMM_W-1]}}, dec_imm};

	////////////////////////////////////////////////////////////////////////////
	// Hazard compare against both writers
	// r0 is never forwarded
	assign a_ex_hit = (ra_addr != '0) && fwd.ex_valid && (fwd.ex_rd == ra_addr);
	assign a_wb_hit = (ra_addr != '0) && fwd.wb_valid && (fwd.wb_rd == ra_addr);
	assign b_ex_hit = (rb_addr != '0) && fwd.ex_valid && (fwd.ex_rd == rb_addr);
	assign b_wb_hit = (rb_addr != '0) && fwd.wb_valid && (fwd.wb_rd == rb_addr);

	// Execute is the younger writer, so it wins
	assign sel_a = a_ex_hit ? pipe_pkg::SEL_EX_FORW :
		a_wb_hit ? pipe_pkg::SEL_WB_FORW : pipe_pkg::SEL_RF;
	assign sel_b = (dec_op == pipe_pkg::OP_ADDI) ? pipe_pkg::SEL_IMM :
		b_ex_hit ? pipe_pkg::SEL_EX_FORW :
		b_wb_hit ? pipe_pkg::SEL_WB_FORW : pipe_pkg::SEL_RF;

	////////////////////////////////////////////////////////////////////////////
	// Issue into execute
	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.valid <= 1'b0;
		end else if (!ex_freeze) begin
			// Decode-only freeze sends a bubble and NOP never reaches write-back
			id_ex.valid <= dec_valid && !id_freeze && (dec_op != pipe_pkg::OP_NOP);
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			id_ex.op <= dec_op;
			id_ex.rd <= dec_rd;
		end
	end

	// Source keeps the offered word steady until decode takes it
	assert property (@(posedge clk) disable iff (reset)
		(instr_valid && !instr_ready) |=> (!instr_valid || $stable(instr)));

endmodule

`default_nettype wire

// File: verilog/operand_mux.sv
/*
 * Operand forwarding muxes and the execute operand registers.
 * Saved flag keeps a captured operand through one decode-only freeze.
 */
`default_nettype none

module operand_mux (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   id_freeze,
	input  wire                   ex_freeze,
	input  wire pipe_pkg::word_t  rf_data_a,
	input  wire pipe_pkg::word_t  rf_data_b,
	input  wire pipe_pkg::word_t  simm,
	input  wire pipe_pkg::opsel_t sel_a,
	input  wire pipe_pkg::opsel_t sel_b,
	fwd_if.mux_mp                 fwd,
	id_ex_if.operand_mp           id_ex
);

	// Index 0 is operand A and index 1 is operand B
	pipe_pkg::word_t muxed [2];
	pipe_pkg::word_t opnd_q [2];
	logic            saved [2];

	////////////////////////////////////////////////////////////////////////////
	// Source select
	always_comb begin
		case (sel_a)
			pipe_pkg::SEL_EX_FORW: muxed[0] = fwd.ex_forw;
			pipe_pkg::SEL_WB_FORW: muxed[0] = fwd.wb_forw;
			default:               muxed[0] = rf_data_a;
		endcase
		case (sel_b)
			pipe_pkg::SEL_IMM:     muxed[1] = simm;
			pipe_pkg::SEL_EX_FORW: muxed[1] = fwd.ex_forw;
			pipe_pkg::SEL_WB_FORW: muxed[1] = fwd.wb_forw;
			default:               muxed[1] = rf_data_b;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand registers
	// Capture whenever execute runs and nothing is saved
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (!ex_freeze && !saved[i]) begin
				opnd_q[i] <= muxed[i];
			end
		end
	end

	// Set on the first decode-only freeze cycle and clear once both run
	always_ff @(posedge clk) begin
		if (reset) begin
			saved <= '{default: 1'b0};
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!ex_freeze && id_freeze && !saved[i]) begin
					saved[i] <= 1'b1;
				end else if (!ex_freeze && !id_freeze) begin
					saved[i] <= 1'b0;
				end
			end
		end
	end

	assign id_ex.operand_a = opnd_q[0];
	assign id_ex.operand_b = opnd_q[1];

	// Execute never freezes while decode keeps running
	assert property (@(posedge clk) disable iff (reset)
		ex_freeze |-> id_freeze);

	// A decode-only freeze lasts a single running cycle
	// The bubble behind a finished MUL lets decode move again
	assert property (@(posedge clk) disable iff (reset)
		((saved[0] || saved[1]) && !ex_freeze) |-> !id_freeze);

endmodule

`default_nettype wire

// File: verilog/pipe_if.sv
/*
 * Decode to execute issue bundle and the forwarding return path.
 * Signal groups only, all timing lives in the stage modules.
 */
`default_nettype none

// Issued instruction, control from decode and operands from the mux
interface id_ex_if;
	logic                valid;
	pipe_pkg::opcode_t   op;
	pipe_pkg::reg_addr_t rd;
	pipe_pkg::word_t     operand_a;
	pipe_pkg::word_t     operand_b;

	modport decode_mp (output valid, op, rd);
	modport operand_mp (output operand_a, operand_b);
	modport execute_mp (input valid, op, rd, operand_a, operand_b);
endinterface

// Forward sources from execute and result back to decode
interface fwd_if;
	// Execute side, valid only when the result is final
	logic                ex_valid;
	pipe_pkg::reg_addr_t ex_rd;
	pipe_pkg::word_t     ex_forw;
	// Result register side
	logic                wb_valid;
	pipe_pkg::reg_addr_t wb_rd;
	pipe_pkg::word_t     wb_forw;

	modport ex_mp (output ex_valid, ex_rd, ex_forw);
	modport wb_mp (output wb_valid, wb_rd, wb_forw);
	modport decode_mp (input ex_valid, ex_rd, ex_forw, wb_valid, wb_rd, wb_forw);
	modport mux_mp (input ex_forw, wb_forw);
endinterface

`default_nettype wire

// File: verilog/pipe_pkg.sv
/*
 * Widths, opcodes and operand select codes shared by the whole pipeline slice.
 * Instruction fields sit at fixed positions, MSB first: opcode, rd, ra, rb, imm.
 */
`default_nettype none

package pipe_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path widths
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;
	localparam int INSTR_W    = 24;
	localparam int OPC_W      = 4;
	localparam int IMM_W      = 8;
	localparam int SEL_W      = 2;
	localparam int SHAMT_W    = $clog2(WORD_W);

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [INSTR_W-1:0]    instr_t;
	typedef logic [IMM_W-1:0]      imm_t;
	typedef logic [OPC_W-1:0]      opcode_t;
	typedef logic [SEL_W-1:0]      opsel_t;

	// Field positions inside instr_t
	localparam int OPC_MSB = INSTR_W - 1;
	localparam int RD_MSB  = OPC_MSB - OPC_W;
	localparam int RA_MSB  = RD_MSB - REG_ADDR_W;
	localparam int RB_MSB  = RA_MSB - REG_ADDR_W;
	localparam int IMM_MSB = RB_MSB - REG_ADDR_W;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes
	localparam opcode_t OP_NOP  = 4'd0;
	localparam opcode_t OP_ADD  = 4'd1;
	localparam opcode_t OP_SUB  = 4'd2;
	localparam opcode_t OP_AND  = 4'd3;
	localparam opcode_t OP_OR   = 4'd4;
	localparam opcode_t OP_XOR  = 4'd5;
	localparam opcode_t OP_SLL  = 4'd6;
	localparam opcode_t OP_ADDI = 4'd7;
	localparam opcode_t OP_MUL  = 4'd8;

	// Operand select, immediate only valid on operand B
	localparam opsel_t SEL_RF      = 2'd0;
	localparam opsel_t SEL_IMM     = 2'd1;
	localparam opsel_t SEL_EX_FORW = 2'd2;
	localparam opsel_t SEL_WB_FORW = 2'd3;

	////////////////////////////////////////////////////////////////////////////
	// Iterative multiplier, one 8-bit slice of operand B per step
	localparam int MUL_STEPS  = 4;
	localparam int MUL_STEP_W = WORD_W / MUL_STEPS;
	localparam int MUL_CNT_W  = $clog2(MUL_STEPS);

	typedef logic [MUL_CNT_W-1:0] mul_cnt_t;

	localparam mul_cnt_t MUL_LAST = mul_cnt_t'(MUL_STEPS - 1);

	typedef enum logic {
		MUL_IDLE,
		MUL_BUSY
	} mul_state_e;

endpackage

`default_nettype wire

// File: verilog/pipe_top.sv
/*
 * Three-stage integer pipe: decode, execute, result, with operand forwarding.
 * Results leave in issue order, one wb_valid pulse per non-NOP instruction.
 */
`default_nettype none

module pipe_top (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      instr_valid,
	input  wire pipe_pkg::instr_t    instr,
	input  wire                      hold,
	output logic                     instr_ready,
	output logic                     wb_valid,
	output pipe_pkg::reg_addr_t      wb_addr,
	output pipe_pkg::word_t          wb_data
);

	// Register file ports
	pipe_pkg::reg_addr_t ra_addr;
	pipe_pkg::reg_addr_t rb_addr;
	pipe_pkg::word_t     rf_data_a;
	pipe_pkg::word_t     rf_data_b;
	logic                we;
	pipe_pkg::reg_addr_t wa;
	pipe_pkg::word_t     wd;

	// Decode to operand mux
	pipe_pkg::word_t     simm;
	pipe_pkg::opsel_t    sel_a;
	pipe_pkg::opsel_t    sel_b;

	// Freezes and execute to result
	logic                id_freeze;
	logic                ex_freeze;
	logic                ex_valid;
	pipe_pkg::reg_addr_t ex_rd;
	pipe_pkg::word_t     ex_result;

	id_ex_if id_ex ();
	fwd_if   fwd ();

	reg_file u_reg_file (
		.clk     (clk),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (rf_data_a),
		.rb_data (rf_data_b),
		.we      (we),
		.wa      (wa),
		.wd      (wd)
	);

	instr_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_ready (instr_ready),
		.id_freeze   (id_freeze),
		.ex_freeze   (ex_freeze),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.simm        (simm),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.id_ex       (id_ex.decode_mp),
		.fwd         (fwd.decode_mp)
	);

	operand_mux u_operand_mux (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.fwd       (fwd.mux_mp),
		.id_ex     (id_ex.operand_mp)
	);

	alu_execute u_execute (
		.clk       (clk),
		.reset     (reset),
		.hold      (hold),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_ex     (id_ex.execute_mp),
		.fwd       (fwd.ex_mp),
		.ex_valid  (ex_valid),
		.ex_rd     (ex_rd),
		.ex_result (ex_result)
	);

	result_stage u_result (
		.clk       (clk),
		.reset     (reset),
		.hold      (hold),
		.ex_freeze (ex_freeze),
		.ex_valid  (ex_valid),
		.ex_rd     (ex_rd),
		.ex_result (ex_result),
		.fwd       (fwd.wb_mp),
		.we        (we),
		.wa        (wa),
		.wd        (wd),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/*
 * 16 x 32 register file, two combinational reads and one clocked write.
 * r0 reads as zero and ignores writes, contents are undefined after power-up.
 */
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire pipe_pkg::reg_addr_t ra_addr,
	input  wire pipe_pkg::reg_addr_t rb_addr,
	output pipe_pkg::word_t          ra_data,
	output pipe_pkg::word_t          rb_data,
	input  wire                      we,
	input  wire pipe_pkg::reg_addr_t wa,
	input  wire pipe_pkg::word_t     wd
);

	pipe_pkg::word_t regs [pipe_pkg::NUM_REGS];

	// Write port, r0 is never stored
	always_ff @(posedge clk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Read ports, no bypass of a same-cycle write
	// Result stage forwarding covers that case
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

`default_nettype wire

// File: verilog/result_stage.sv
/*
 * Result register, write-back port and register file write strobe.
 * Output has no ready, back-pressure comes only through hold.
 */
`default_nettype none

module result_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      hold,
	input  wire                      ex_freeze,
	input  wire                      ex_valid,
	input  wire pipe_pkg::reg_addr_t ex_rd,
	input  wire pipe_pkg::word_t     ex_result,
	fwd_if.wb_mp                     fwd,
	output logic                     we,
	output pipe_pkg::reg_addr_t      wa,
	output pipe_pkg::word_t          wd,
	output logic                     wb_valid,
	output pipe_pkg::reg_addr_t      wb_addr,
	output pipe_pkg::word_t          wb_data
);

	logic                res_valid;
	pipe_pkg::reg_addr_t res_rd;
	pipe_pkg::word_t     res_data;

	// Busy MUL leaves a bubble behind, hold keeps everything
	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else if (!hold) begin
			res_valid <= ex_valid && !ex_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && !ex_freeze) begin
			res_rd   <= ex_rd;
			res_data <= ex_result;
		end
	end

	// One pulse per result, write lands at the end of that cycle
	assign wb_valid = res_valid && !hold;
	assign wb_addr  = res_rd;
	assign wb_data  = res_data;

	assign we = wb_valid;
	assign wa = res_rd;
	assign wd = res_data;

	// Forward source stays visible during hold
	assign fwd.wb_valid = res_valid;
	assign fwd.wb_rd    = res_rd;
	assign fwd.wb_forw  = res_data;

endmodule

`default_nettype wire
